// ==== led_matrix_pkg.sv ====
// Shared types and constants for the LED matrix driver; referenced by scoped name from each module
package led_matrix_pkg;

	// Address width carried in host commands, modules slice the low bits
	localparam int FB_ADDR_W = 16;

	// Binary code modulation depth
	localparam int PLANES = 6;

	// First byte of every five-byte command
	typedef enum logic [7:0] {
		OP_PIXEL  = 8'h01,
		OP_CONFIG = 8'h02
	} cmd_op_e;

	// Frame buffer word, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Display settings word
	// rgb_enable bit 0 is red, bit 1 green, bit 2 blue
	typedef struct packed {
		logic [6:0] spare;
		logic [5:0] brightness_enable;
		logic [2:0] rgb_enable;
	} disp_cfg_t;

	// Command payload, meaning picked by the opcode
	typedef union packed {
		rgb565_t   pixel;
		disp_cfg_t cfg;
	} cmd_payload_u;

	// Loader write request, held until granted
	typedef struct packed {
		logic                 valid;
		logic [FB_ADDR_W-1:0] addr;
		rgb565_t              data;
	} fb_wr_t;

	// Fetch read request, held until granted
	typedef struct packed {
		logic                 valid;
		logic [FB_ADDR_W-1:0] addr;
	} fb_rd_t;

	// Panel pins except the row address
	// rgb bit order matches rgb_enable
	typedef struct packed {
		logic       clk_pixel;
		logic       latch;
		logic       oe_n;
		logic [2:0] rgb_top;
		logic [2:0] rgb_bot;
	} hub75_t;

endpackage

// ==== fb_ram.sv ====
// Single-port RGB565 frame buffer with registered read, one word per pixel
`timescale 1ns/10ps

module fb_ram #(
	parameter int DEPTH = 64
) (
	input  logic                     clk_root,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [15:0]              wdata,
	output logic [15:0]              rdata
);

	logic [15:0] mem [DEPTH];

	// Read-first, output valid the cycle after en
	always_ff @(posedge clk_root) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

// ==== fb_arbiter.sv ====
// Shares the single frame buffer port between pixel fetch reads and loader writes, reads first
`timescale 1ns/10ps

module fb_arbiter #(
	parameter int AW = 6
) (
	input  logic                    clk_root,
	input  logic                    rst_n,
	input  led_matrix_pkg::fb_rd_t  rd_req,
	output logic                    rd_grant,
	input  led_matrix_pkg::fb_wr_t  wr_req,
	output logic                    wr_grant,
	output logic                    mem_en,
	output logic                    mem_we,
	output logic [AW-1:0]           mem_addr,
	output logic [15:0]             mem_wdata,
	input  logic [15:0]             mem_rdata,
	output led_matrix_pkg::rgb565_t rd_data
);

	// Fixed priority, the scan has no slack so reads always win
	assign rd_grant = rd_req.valid;
	assign wr_grant = wr_req.valid && !rd_req.valid;

	// Port steering
	assign mem_en = rd_grant || wr_grant;
	assign mem_we = wr_grant;
	assign mem_addr = rd_grant ? rd_req.addr[AW-1:0] : wr_req.addr[AW-1:0];
	assign mem_wdata = wr_req.data;

	// RAM output register already holds the word a cycle after grant
	assign rd_data = mem_rdata;

	a_grant_onehot: assert property (@(posedge clk_root) disable iff (!rst_n)
		!(rd_grant && wr_grant))
		else $error("read and write granted together");

	// Loader keeps a refused write steady until served
	a_wr_held: assert property (@(posedge clk_root) disable iff (!rst_n)
		wr_req.valid && !wr_grant |=> wr_req.valid && $stable(wr_req))
		else $error("write request changed before grant");

endmodule

// ==== cmd_loader.sv ====
// Host byte FIFO with credit return and five-byte command parser; feeds frame buffer writes and settings
`timescale 1ns/10ps

module cmd_loader #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      clk_root,
	input  logic                      rst_n,
	input  logic                      byte_valid,
	input  logic [7:0]                byte_data,
	output logic                      credit_return,
	output led_matrix_pkg::fb_wr_t    wr_req,
	input  logic                      wr_grant,
	output led_matrix_pkg::disp_cfg_t cfg
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [7:0]                          fifo_mem [FIFO_DEPTH];
	logic [PW-1:0]                       wr_ptr;
	logic [PW-1:0]                       rd_ptr;
	logic [CNT_W-1:0]                    count;
	logic                                full;
	logic                                pop;
	logic [7:0]                          pop_byte;
	logic [2:0]                          byte_cnt;
	logic                                last_byte;
	led_matrix_pkg::cmd_op_e             opcode;
	logic [7:0]                          addr_hi;
	logic [7:0]                          addr_lo;
	logic [7:0]                          pl_hi;
	led_matrix_pkg::cmd_payload_u        payload;
	logic                                wr_valid;
	logic [led_matrix_pkg::FB_ADDR_W-1:0] wr_addr;
	led_matrix_pkg::rgb565_t             wr_data;

	assign full = (count == CNT_W'(FIFO_DEPTH));
	// Parser stalls while a pixel write waits for the memory
	assign pop = (count != '0) && !wr_valid;
	assign pop_byte = fifo_mem[rd_ptr];
	assign last_byte = pop && (byte_cnt == 3'd4);
	// Low payload byte comes straight from the FIFO head
	assign payload = {pl_hi, pop_byte};
	assign wr_req = '{valid: wr_valid, addr: wr_addr, data: wr_data};

	// Byte storage
	always_ff @(posedge clk_root) begin
		if (byte_valid) begin
			fifo_mem[wr_ptr] <= byte_data;
		end
	end

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (byte_valid) begin
				wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(byte_valid) - CNT_W'(pop);
		end
	end

	// Command fields, plain data capture
	always_ff @(posedge clk_root) begin
		if (pop) begin
			case (byte_cnt)
				3'd0: opcode <= led_matrix_pkg::cmd_op_e'(pop_byte);
				3'd1: addr_hi <= pop_byte;
				3'd2: addr_lo <= pop_byte;
				3'd3: pl_hi <= pop_byte;
				default: begin
					wr_addr <= {addr_hi, addr_lo};
					wr_data <= payload.pixel;
				end
			endcase
		end
	end

	// Byte counter, credits, write handshake, settings
	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			credit_return <= 1'b0;
			wr_valid <= 1'b0;
			cfg <= '{spare: '0, brightness_enable: '1, rgb_enable: '1};
		end else begin
			// One credit back per byte leaving the FIFO
			credit_return <= pop;
			if (wr_grant) begin
				wr_valid <= 1'b0;
			end
			if (pop) begin
				byte_cnt <= (byte_cnt == 3'd4) ? '0 : byte_cnt + 1'b1;
			end
			if (last_byte && opcode == led_matrix_pkg::OP_PIXEL) begin
				wr_valid <= 1'b1;
			end
			// Unknown opcodes fall through, bytes already consumed
			if (last_byte && opcode == led_matrix_pkg::OP_CONFIG) begin
				cfg <= payload.cfg;
			end
		end
	end

	// Host must hold a credit for every byte it sends
	a_fifo_no_overflow: assert property (@(posedge clk_root) disable iff (!rst_n)
		byte_valid |-> !full)
		else $error("byte FIFO written while full");

endmodule

// ==== pixel_fetch.sv ====
// Reads the top and bottom pixels of a column and reduces them to bits for the current plane
`timescale 1ns/10ps

module pixel_fetch #(
	parameter int COLS = 8,
	parameter int ROWS = 8
) (
	input  logic                             clk_root,
	input  logic                             rst_n,
	input  logic                             load_start,
	input  logic [((COLS > 1) ? $clog2(COLS) : 1)-1:0]     column,
	input  logic [((ROWS > 2) ? $clog2(ROWS / 2) : 1)-1:0] row,
	input  logic [2:0]                       plane,
	input  led_matrix_pkg::disp_cfg_t        cfg,
	output led_matrix_pkg::fb_rd_t           rd_req,
	input  logic                             rd_grant,
	input  led_matrix_pkg::rgb565_t          rd_data,
	output logic                             pixel_valid,
	output logic [2:0]                       rgb_top,
	output logic [2:0]                       rgb_bot
);

	localparam int AW = led_matrix_pkg::FB_ADDR_W;
	// Bottom half starts this many words later
	localparam logic [AW-1:0] HALF_OFS = AW'((ROWS / 2) * COLS);

	typedef enum logic [1:0] {S_IDLE, S_TOP, S_BOT} state_t;

	state_t                  state;
	logic                    rd_valid;
	logic [AW-1:0]           rd_addr;
	logic [AW-1:0]           top_addr;
	logic [AW-1:0]           bot_addr;
	logic                    cap_top;
	logic                    cap_bot;
	led_matrix_pkg::rgb565_t top_pix;
	led_matrix_pkg::rgb565_t bot_pix;

	// Widen red and blue to six bits, pick the plane bit, mask by settings
	function automatic logic [2:0] plane_bits(
		input led_matrix_pkg::rgb565_t   px,
		input led_matrix_pkg::disp_cfg_t c,
		input logic [2:0]                pl
	);
		logic [5:0] red_w;
		logic [5:0] blue_w;
		logic [2:0] bits;
		red_w = {px.red, px.red[4]};
		blue_w = {px.blue, px.blue[4]};
		bits = {blue_w[pl], px.green[pl], red_w[pl]};
		return bits & c.rgb_enable & {3{c.brightness_enable[pl]}};
	endfunction

	assign top_addr = AW'(row) * AW'(COLS) + AW'(column);
	assign rd_req = '{valid: rd_valid, addr: rd_addr};
	assign rgb_top = plane_bits(top_pix, cfg, plane);
	assign rgb_bot = plane_bits(bot_pix, cfg, plane);

	// Addresses and captured words
	always_ff @(posedge clk_root) begin
		if (state == S_IDLE && load_start) begin
			rd_addr <= top_addr;
			bot_addr <= top_addr + HALF_OFS;
		end
		if (state == S_TOP && rd_grant) begin
			rd_addr <= bot_addr;
		end
		if (cap_top) begin
			top_pix <= rd_data;
		end
		if (cap_bot) begin
			bot_pix <= rd_data;
		end
	end

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			state <= S_IDLE;
			rd_valid <= 1'b0;
			cap_top <= 1'b0;
			cap_bot <= 1'b0;
			pixel_valid <= 1'b0;
		end else begin
			// Data arrives the cycle after each grant
			cap_top <= (state == S_TOP) && rd_grant;
			cap_bot <= (state == S_BOT) && rd_grant;
			pixel_valid <= cap_bot;
			case (state)
				S_IDLE: begin
					if (load_start) begin
						rd_valid <= 1'b1;
						state <= S_TOP;
					end
				end
				S_TOP: begin
					if (rd_grant) begin
						state <= S_BOT;
					end
				end
				default: begin
					if (rd_grant) begin
						rd_valid <= 1'b0;
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== matrix_scan.sv ====
// Panel scan sequencer; walks columns, latches lines and times output enable per brightness plane
`timescale 1ns/10ps

module matrix_scan #(
	parameter int COLS    = 8,
	parameter int ROWS    = 8,
	parameter int OE_BASE = 2
) (
	input  logic                             clk_root,
	input  logic                             rst_n,
	output logic                             load_start,
	output logic [((COLS > 1) ? $clog2(COLS) : 1)-1:0]     column,
	output logic [((ROWS > 2) ? $clog2(ROWS / 2) : 1)-1:0] row,
	output logic [2:0]                       plane,
	input  logic                             pixel_valid,
	input  logic [2:0]                       rgb_top_in,
	input  logic [2:0]                       rgb_bot_in,
	output led_matrix_pkg::hub75_t           panel,
	output logic [((ROWS > 2) ? $clog2(ROWS / 2) : 1)-1:0] row_addr
);

	localparam int CW = (COLS > 1) ? $clog2(COLS) : 1;
	localparam int RW = (ROWS > 2) ? $clog2(ROWS / 2) : 1;
	localparam int OW = $clog2((OE_BASE << (led_matrix_pkg::PLANES - 1)) + 1);

	typedef enum logic [2:0] {S_FETCH, S_WAIT, S_SHIFT, S_LATCH, S_DISPLAY} state_t;

	state_t        state;
	logic [OW-1:0] oe_cnt;
	logic          clk_pixel;
	logic          latch;
	logic          oe_n;
	logic [2:0]    rgb_top;
	logic [2:0]    rgb_bot;

	assign panel = '{clk_pixel: clk_pixel, latch: latch, oe_n: oe_n,
		rgb_top: rgb_top, rgb_bot: rgb_bot};

	// Shift data, taken when the fetcher answers
	always_ff @(posedge clk_root) begin
		if (state == S_WAIT && pixel_valid) begin
			rgb_top <= rgb_top_in;
			rgb_bot <= rgb_bot_in;
		end
	end

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			state <= S_FETCH;
			load_start <= 1'b0;
			clk_pixel <= 1'b0;
			latch <= 1'b0;
			oe_n <= 1'b1;
			column <= '0;
			row <= '0;
			plane <= '0;
			row_addr <= '0;
			oe_cnt <= '0;
		end else begin
			load_start <= 1'b0;
			clk_pixel <= 1'b0;
			latch <= 1'b0;
			case (state)
				S_FETCH: begin
					load_start <= 1'b1;
					state <= S_WAIT;
				end
				// Fetch time depends on write traffic
				S_WAIT: begin
					if (pixel_valid) begin
						clk_pixel <= 1'b1;
						state <= S_SHIFT;
					end
				end
				S_SHIFT: begin
					if (column == CW'(COLS - 1)) begin
						column <= '0;
						latch <= 1'b1;
						row_addr <= row;
						state <= S_LATCH;
					end else begin
						column <= column + 1'b1;
						state <= S_FETCH;
					end
				end
				// Weight doubles with each plane
				S_LATCH: begin
					oe_n <= 1'b0;
					oe_cnt <= OW'((OE_BASE << plane) - 1);
					state <= S_DISPLAY;
				end
				default: begin
					if (oe_cnt == '0) begin
						oe_n <= 1'b1;
						state <= S_FETCH;
						if (plane == 3'(led_matrix_pkg::PLANES - 1)) begin
							plane <= '0;
							row <= (row == RW'(ROWS / 2 - 1)) ? '0 : row + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						oe_cnt <= oe_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// Panel stays dark while a line shifts
	a_dark_while_shift: assert property (@(posedge clk_root) disable iff (!rst_n)
		panel.clk_pixel |-> panel.oe_n)
		else $error("output enabled during pixel shift");

endmodule

// ==== led_matrix_top.sv ====
// LED matrix driver top level; joins loader, fetch, scan, arbiter and frame buffer, sets sizes
`timescale 1ns/10ps

module led_matrix_top #(
	parameter int COLS       = 8,
	parameter int ROWS       = 8,
	parameter int FIFO_DEPTH = 4,
	parameter int OE_BASE    = 2
) (
	input  logic                   clk_root,
	input  logic                   rst_n,
	input  logic                   byte_valid,
	input  logic [7:0]             byte_data,
	output logic                   credit_return,
	output led_matrix_pkg::hub75_t panel,
	output logic [((ROWS > 2) ? $clog2(ROWS / 2) : 1)-1:0] row_addr
);

	localparam int AW = $clog2(COLS * ROWS);
	localparam int CW = (COLS > 1) ? $clog2(COLS) : 1;
	localparam int RW = (ROWS > 2) ? $clog2(ROWS / 2) : 1;

	led_matrix_pkg::fb_wr_t    wr_req;
	logic                      wr_grant;
	led_matrix_pkg::fb_rd_t    rd_req;
	logic                      rd_grant;
	led_matrix_pkg::rgb565_t   rd_data;
	led_matrix_pkg::disp_cfg_t cfg;
	logic                      mem_en;
	logic                      mem_we;
	logic [AW-1:0]             mem_addr;
	logic [15:0]               mem_wdata;
	logic [15:0]               mem_rdata;
	logic                      load_start;
	logic [CW-1:0]             column;
	logic [RW-1:0]             row;
	logic [2:0]                plane;
	logic                      pixel_valid;
	logic [2:0]                rgb_top;
	logic [2:0]                rgb_bot;

	cmd_loader #(.FIFO_DEPTH(FIFO_DEPTH)) u_cmd_loader (
		.clk_root(clk_root), .rst_n(rst_n),
		.byte_valid(byte_valid), .byte_data(byte_data), .credit_return(credit_return),
		.wr_req(wr_req), .wr_grant(wr_grant), .cfg(cfg)
	);

	fb_arbiter #(.AW(AW)) u_fb_arbiter (
		.clk_root(clk_root), .rst_n(rst_n),
		.rd_req(rd_req), .rd_grant(rd_grant), .wr_req(wr_req), .wr_grant(wr_grant),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .rd_data(rd_data)
	);

	fb_ram #(.DEPTH(COLS * ROWS)) u_fb_ram (
		.clk_root(clk_root), .en(mem_en), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	matrix_scan #(.COLS(COLS), .ROWS(ROWS), .OE_BASE(OE_BASE)) u_matrix_scan (
		.clk_root(clk_root), .rst_n(rst_n),
		.load_start(load_start), .column(column), .row(row), .plane(plane),
		.pixel_valid(pixel_valid), .rgb_top_in(rgb_top), .rgb_bot_in(rgb_bot),
		.panel(panel), .row_addr(row_addr)
	);

	pixel_fetch #(.COLS(COLS), .ROWS(ROWS)) u_pixel_fetch (
		.clk_root(clk_root), .rst_n(rst_n),
		.load_start(load_start), .column(column), .row(row), .plane(plane), .cfg(cfg),
		.rd_req(rd_req), .rd_grant(rd_grant), .rd_data(rd_data),
		.pixel_valid(pixel_valid), .rgb_top(rgb_top), .rgb_bot(rgb_bot)
	);

endmodule

// ==== tb_led_matrix.sv ====
// Testbench for the LED matrix driver; replays led_matrix_vectors.txt and checks the panel lines
`timescale 1ns/10ps

module tb_led_matrix;

	localparam int COLS       = 8;
	localparam int ROWS       = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int OE_BASE    = 2;
	localparam int RW         = $clog2(ROWS / 2);
	localparam int PLANES     = led_matrix_pkg::PLANES;
	// One line per row and plane in a frame
	localparam int LINES      = PLANES * ROWS / 2;
	// Frame length bound from about seven cycles per column plus display time
	localparam int FRAME_CYCLES = (ROWS / 2) * (PLANES * (COLS * 8 + 4) + (OE_BASE << PLANES));

	logic                   clk_root;
	logic                   rst_n;
	logic                   byte_valid;
	logic [7:0]             byte_data;
	logic                   credit_return;
	led_matrix_pkg::hub75_t panel;
	logic [RW-1:0]          row_addr;

	int          credits = FIFO_DEPTH;
	int          bytes_sent = 0;
	int          bytes_returned = 0;
	int          timeout_cycles = 0;
	logic [15:0] lfsr_state = 16'd60;
	int          latch_count = 0;
	int          col_cnt = 0;
	int          oe_low = 0;
	int          disp_plane = 0;
	logic        disp_active = 1'b0;
	logic [31:0] cur_top = '0;
	logic [31:0] cur_bot = '0;
	logic [31:0] line_top [LINES];
	logic [31:0] line_bot [LINES];
	string       vectors [$];

	led_matrix_top #(
		.COLS(COLS), .ROWS(ROWS), .FIFO_DEPTH(FIFO_DEPTH), .OE_BASE(OE_BASE)
	) u_led_matrix_top (
		.clk_root(clk_root), .rst_n(rst_n),
		.byte_valid(byte_valid), .byte_data(byte_data), .credit_return(credit_return),
		.panel(panel), .row_addr(row_addr)
	);

	initial begin
		clk_root = 1'b0;
		forever #5 clk_root = ~clk_root;
	end

	// Compare a value with its expected value
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic reject_vector(input int index);
		$display("Vector line %0d is malformed: %s", index, vectors[index]);
		$display("Done: errors found");
		$fatal(1, "bad vector file");
	endtask

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] next_lfsr(input logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], fb};
	endfunction

	// Random idle gap of 0 to 3 cycles before each byte
	task automatic send_byte(input logic [7:0] value);
		int gap;
		lfsr_state = next_lfsr(lfsr_state);
		gap = int'(lfsr_state[0]);
		lfsr_state = next_lfsr(lfsr_state);
		gap = gap + 2 * int'(lfsr_state[0]);
		repeat (gap) begin
			@(posedge clk_root);
			byte_valid <= 1'b0;
		end
		@(posedge clk_root);
		// Hold off while no credit is left
		while (credits == 0) begin
			byte_valid <= 1'b0;
			@(posedge clk_root);
		end
		byte_valid <= 1'b1;
		byte_data <= value;
		credits--;
		bytes_sent++;
	endtask

	task automatic send_command(input logic [7:0] op, input logic [7:0] addr_hi,
		input logic [7:0] addr_lo, input logic [7:0] pl_hi, input logic [7:0] pl_lo);
		send_byte(op);
		send_byte(addr_hi);
		send_byte(addr_lo);
		send_byte(pl_hi);
		send_byte(pl_lo);
	endtask

	// Stop the stream and let every byte drain
	task automatic settle_loader();
		@(posedge clk_root);
		byte_valid <= 1'b0;
		wait (credits == FIFO_DEPTH);
		// Room for the last pixel write to win the memory port
		repeat (16) @(posedge clk_root);
	endtask

	// Record one complete frame that starts after the current line
	task automatic capture_frame();
		int first;
		first = ((latch_count + 1 + LINES - 1) / LINES) * LINES;
		wait (latch_count >= first + LINES);
	endtask

	// Panel and credit monitor on the falling edge
	always @(negedge clk_root) begin
		if (rst_n) begin
			if (credit_return) begin
				check_value("credit return beyond FIFO depth", credits < FIFO_DEPTH, 1'b1);
				credits++;
				bytes_returned++;
			end
			if (panel.clk_pixel) begin
				cur_top = {cur_top[27:0], 1'b0, panel.rgb_top};
				cur_bot = {cur_bot[27:0], 1'b0, panel.rgb_bot};
				col_cnt++;
			end
			if (panel.latch) begin
				check_value("columns shifted before latch", col_cnt, COLS);
				check_value("row_addr at latch", row_addr,
					32'((latch_count / PLANES) % (ROWS / 2)));
				check_value("latch while panel lit", disp_active, 1'b0);
				line_top[latch_count % LINES] = cur_top;
				line_bot[latch_count % LINES] = cur_bot;
				disp_plane = latch_count % PLANES;
				disp_active = 1'b1;
				oe_low = 0;
				col_cnt = 0;
				latch_count++;
			end
			// Display window follows each latch
			if (!panel.oe_n) begin
				check_value("oe_n low without a latch", disp_active, 1'b1);
				oe_low++;
			end else if (disp_active && oe_low > 0) begin
				check_value("oe_n low cycles", oe_low, 32'(OE_BASE << disp_plane));
				disp_active = 1'b0;
			end
		end
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk_root);
		$display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int          fd;
		string       line;
		byte         kind;
		int          fields;
		logic [15:0] addr;
		logic        pending;
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] v4;
		rst_n = 1'b0;
		byte_valid = 1'b0;
		byte_data = '0;
		pending = 1'b1;
		fd = $fopen("led_matrix_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file led_matrix_vectors.txt");
			$display("Done: errors found");
			$fatal(1, "missing vector file");
		end
		// Keep command and check lines only
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
				vectors.push_back(line);
			end
		end
		$fclose(fd);
		timeout_cycles = vectors.size() * 3 * FRAME_CYCLES + COLS * ROWS * 5 * 16 + 2000;

		// Idle panel and no credits while in reset
		repeat (4) begin
			@(negedge clk_root);
			check_value("oe_n in reset", panel.oe_n, 1'b1);
			check_value("latch in reset", panel.latch, 1'b0);
			check_value("clk_pixel in reset", panel.clk_pixel, 1'b0);
			check_value("credit_return in reset", credit_return, 1'b0);
		end
		@(posedge clk_root);
		rst_n <= 1'b1;

		// Known black frame before the vectors
		for (int a = 0; a < COLS * ROWS; a++) begin
			addr = 16'(a);
			send_command(8'h01, addr[15:8], addr[7:0], 8'h00, 8'h00);
		end

		foreach (vectors[i]) begin
			kind = vectors[i].getc(0);
			if (kind == "W") begin
				fields = $sscanf(vectors[i], "W %h %h %h %h %h", v0, v1, v2, v3, v4);
				if (fields != 5) begin
					reject_vector(i);
				end
				send_command(v0[7:0], v1[7:0], v2[7:0], v3[7:0], v4[7:0]);
				pending = 1'b1;
			end else if (kind == "C") begin
				fields = $sscanf(vectors[i], "C %d %d %h %h", v0, v1, v2, v3);
				if (fields != 4 || v0 >= ROWS / 2 || v1 >= PLANES) begin
					reject_vector(i);
				end
				// New commands need a fresh frame
				if (pending) begin
					settle_loader();
					capture_frame();
					pending = 1'b0;
				end
				check_value($sformatf("row %0d plane %0d top", v0, v1),
					line_top[v0 * PLANES + v1], v2);
				check_value($sformatf("row %0d plane %0d bottom", v0, v1),
					line_bot[v0 * PLANES + v1], v3);
			end else begin
				reject_vector(i);
			end
		end

		// Every sent byte must come back as a credit before the end
		settle_loader();
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== led_matrix_vectors.txt ====
# W opcode addr_hi addr_lo payload_hi payload_lo, command bytes in hex
# C row plane top bottom, one hex digit per column from column 0, digit is {blue,green,red}
W 01 00 00 F8 00
W 07 00 00 FF FF
W 01 00 01 05 40
W 01 00 07 00 10
W 01 00 20 FF FF
W 01 00 23 28 0C
W 01 00 14 07 E0
C 0 0 10000004 70000000
C 0 1 12000000 70010000
C 0 2 10000000 70000000
C 0 3 12000000 70050000
C 0 4 10000000 70040000
C 0 5 12000004 70000000
C 1 0 00000000 00000000
C 2 2 00002000 00000000
W 02 00 00 01 BD
C 0 0 10000004 50000000
C 0 1 10000000 50010000
C 0 3 00000000 00000000
C 0 4 10000000 50040000
C 0 5 10000004 50000000
C 2 2 00000000 00000000

// ==== filelist.f ====
led_matrix_pkg.sv
fb_ram.sv
fb_arbiter.sv
cmd_loader.sv
pixel_fetch.sv
matrix_scan.sv
led_matrix_top.sv
tb_led_matrix.sv
